/* compile.f */
verilog/aFifoPkg.sv
verilog/grayCounter.sv
verilog/dualPortRam.sv
verilog/statusFlags.sv
verilog/aFifo.sv
tb/aFifo_assertions.sv
tb/aFifoTb.sv

/* tb/aFifoTb.sv */
//============================================================
// Testbench for the dual-clock FIFO
// LFSR stimulus in phases, queue model, check task, watchdog
//============================================================

`timescale 1ns/1ps
`default_nettype none

module aFifoTb;

   localparam int RClkPeriod    = 40;
   localparam int WClkPeriod    = 56;
   // Writes plus reads over all phases
   localparam int TransferCount = 600;
   localparam int WritesMixA    = 120;
   localparam int WritesTotal   = TransferCount / 2;

   // Stimulus phases
   localparam int PhaseIdle       = 0;
   localparam int PhaseMixA       = 1;
   localparam int PhaseWriteBurst = 2;
   localparam int PhaseReadBurst  = 3;
   localparam int PhaseMixB       = 4;
   localparam int PhaseDrain      = 5;

   logic                           WClk;
   logic                           RClk;
   logic                           PresetEmpty;
   logic [aFifoPkg::DataWidth-1:0] DataIn;
   logic                           WriteEn;
   logic                           Full;
   logic                           ReadEn;
   logic [aFifoPkg::DataWidth-1:0] DataOut;
   logic                           Empty;

   // Model and bookkeeping
   logic [aFifoPkg::DataWidth-1:0] modelQ[$];
   logic [31:0]                    lfsrState = 32'h1591;
   int                             phase = PhaseIdle;
   int                             writeCount = 0;
   int                             readCount = 0;
   int                             droppedWrites = 0;
   int                             blockedReads = 0;
   int                             markCount;
   // Flag and data values the next rising edge acts on
   logic                           fullSeen = 1'b0;
   logic                           emptySeen = 1'b1;
   logic [aFifoPkg::DataWidth-1:0] heldOut = '0;

   aFifo dut (
      .WClk        (WClk),
      .RClk        (RClk),
      .PresetEmpty (PresetEmpty),
      .DataIn      (DataIn),
      .WriteEn     (WriteEn),
      .Full        (Full),
      .ReadEn      (ReadEn),
      .DataOut     (DataOut),
      .Empty       (Empty)
   );

   //============================================================
   // Clocks
   //============================================================

   initial begin
      RClk = 1'b0;
      forever #(RClkPeriod / 2) RClk = ~RClk;
   end

   // Odd offset so no WClk edge ever lines up with an RClk edge
   initial begin
      WClk = 1'b0;
      #7;
      forever #(WClkPeriod / 2) WClk = ~WClk;
   end

   //============================================================
   // Helpers
   //============================================================

   // Galois LFSR, one shift per call
   function automatic logic [31:0] lfsrNext(input logic [31:0] state);
      logic [31:0] nextState;
      nextState = state >> 1;
      if (state[0]) begin
         nextState = nextState ^ 32'hB4BC_D35C;
      end
      return nextState;
   endfunction

   // Collect n random bits, one LFSR step each
   task automatic takeRandom(input int bitCount, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < bitCount; i++) begin
         value     = {value[30:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);
      end
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   endtask

   //============================================================
   // Write side driver and monitor
   //============================================================

   always @(negedge WClk) begin : writeDriver
      logic [31:0] bits;
      fullSeen = Full;
      // Model full means the FIFO must refuse writes
      if (modelQ.size() == aFifoPkg::FifoDepth) begin
         checkValue("Full", Full, 1'b1);
      end
      case (phase)
         PhaseMixA: begin
            takeRandom(2, bits);
            WriteEn = |bits[1:0];
         end
         PhaseMixB: begin
            takeRandom(1, bits);
            WriteEn = bits[0];
         end
         PhaseWriteBurst: WriteEn = 1'b1;
         default: WriteEn = 1'b0;
      endcase
      if (WriteEn) begin
         takeRandom(aFifoPkg::DataWidth, bits);
         DataIn = bits[aFifoPkg::DataWidth-1:0];
      end
   end

   always @(posedge WClk) begin : writeMonitor
      if (!PresetEmpty) begin
         // Full low must never hide a full FIFO
         if (!fullSeen) begin
            checkValue("Full low with model below depth",
                       modelQ.size() < aFifoPkg::FifoDepth, 1'b1);
         end
         if (WriteEn && !fullSeen) begin
            modelQ.push_back(DataIn);
            writeCount++;
         end
         else if (WriteEn) begin
            // Refused write, never stored
            droppedWrites++;
         end
      end
   end

   //============================================================
   // Read side driver and monitor
   //============================================================

   always @(negedge RClk) begin : readDriver
      logic [31:0] bits;
      emptySeen = Empty;
      heldOut   = DataOut;
      if (modelQ.size() == 0) begin
         checkValue("Empty", Empty, 1'b1);
      end
      case (phase)
         PhaseMixA: begin
            takeRandom(1, bits);
            ReadEn = bits[0];
         end
         PhaseMixB: begin
            takeRandom(2, bits);
            ReadEn = &bits[1:0];
         end
         PhaseReadBurst, PhaseDrain: ReadEn = 1'b1;
         default: ReadEn = 1'b0;
      endcase
   end

   always @(posedge RClk) begin : readMonitor
      logic [aFifoPkg::DataWidth-1:0] expectedWord;
      if (!PresetEmpty) begin
         // Empty low must never hide an empty FIFO
         if (!emptySeen) begin
            checkValue("Empty low with model above zero", modelQ.size() > 0, 1'b1);
         end
         if (ReadEn && !emptySeen) begin
            expectedWord = modelQ.pop_front();
            readCount++;
            #1;
            checkValue("DataOut", DataOut, expectedWord);
         end
         else if (ReadEn) begin
            blockedReads++;
            #1;
            checkValue("DataOut held", DataOut, heldOut);
         end
      end
   end

   //============================================================
   // Main sequence
   //============================================================

   initial begin
      PresetEmpty = 1'b1;
      WriteEn     = 1'b0;
      ReadEn      = 1'b0;
      DataIn      = '0;
      repeat (4) @(negedge RClk);
      PresetEmpty = 1'b0;
      // State right after reset
      checkValue("Empty", Empty, 1'b1);
      checkValue("Full", Full, 1'b0);
      checkValue("DataOut", DataOut, '0);
      @(posedge RClk);
      phase = PhaseMixA;
      wait (writeCount >= WritesMixA);
      // Fill up, then keep pushing against Full
      markCount = droppedWrites;
      phase = PhaseWriteBurst;
      wait (droppedWrites >= markCount + 6);
      // Drain, then keep reading against Empty
      markCount = blockedReads;
      phase = PhaseReadBurst;
      wait (readCount == writeCount && blockedReads >= markCount + 6);
      phase = PhaseMixB;
      wait (writeCount >= WritesTotal);
      phase = PhaseDrain;
      wait (readCount == writeCount);
      repeat (4) @(negedge RClk);
      checkValue("Empty after drain", Empty, 1'b1);
      checkValue("model queue size", modelQ.size(), 0);
      if (dut.assertChecker.failCount == 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end
      else begin
         $display("%0d assertion failures", dut.assertChecker.failCount);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   end

   //============================================================
   // Watchdog
   //============================================================

   initial begin
      #(TransferCount * 4 * WClkPeriod);
      $display("ERROR: simulation timed out before all transfers finished");
      $display("SIMULATION FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire

/* tb/aFifo_assertions.sv */
//============================================================
// Bound checker for FIFO flags, Gray pointers and read data
//============================================================

`timescale 1ns/1ps
`default_nettype none

module aFifoAssertions (
   input logic                              WClk,
   input logic                              RClk,
   input logic                              PresetEmpty,
   input logic                              Full,
   input logic                              Empty,
   input logic [aFifoPkg::AddressWidth-1:0] WritePtr,
   input logic [aFifoPkg::AddressWidth-1:0] ReadPtr,
   input logic                              ReadAccept,
   input logic [aFifoPkg::DataWidth-1:0]    DataOut
);

   // Failed assertions, read back by the testbench at the end
   int failCount = 0;

   // Flags describe opposite ends of the FIFO
   flagsExclusive: assert property (@(posedge RClk) disable iff (PresetEmpty)
      !(Full && Empty))
      else begin
         $error("Full and Empty are high together");
         failCount++;
      end

   // Write pointer moves one Gray step at most
   writePtrStep: assert property (@(posedge WClk) disable iff (PresetEmpty)
      $countones(WritePtr ^ $past(WritePtr)) <= 1)
      else begin
         $error("writePtr changed more than one bit");
         failCount++;
      end

   // Same for the read pointer
   readPtrStep: assert property (@(posedge RClk) disable iff (PresetEmpty)
      $countones(ReadPtr ^ $past(ReadPtr)) <= 1)
      else begin
         $error("readPtr changed more than one bit");
         failCount++;
      end

   // Read register only loads on an accepted read
   dataOutHeld: assert property (@(posedge RClk) disable iff (PresetEmpty)
      !ReadAccept |=> $stable(DataOut))
      else begin
         $error("DataOut changed without an accepted read");
         failCount++;
      end

endmodule

// Attach to every aFifo instance
bind aFifo aFifoAssertions assertChecker (
   .WClk        (WClk),
   .RClk        (RClk),
   .PresetEmpty (PresetEmpty),
   .Full        (Full),
   .Empty       (Empty),
   .WritePtr    (writePtr),
   .ReadPtr     (readPtr),
   .ReadAccept  (readAccept),
   .DataOut     (DataOut)
);

`default_nettype wire

/* verilog/aFifo.sv */
//============================================================
// Dual-clock FIFO top level
// Enable gating, pointer counters, storage and status flags
//============================================================

`timescale 1ns/1ps
`default_nettype none

module aFifo (
   //============================================================
   // Clocks and reset
   //============================================================
   // Write domain clock
   input  logic                           WClk,
   // Read domain clock
   input  logic                           RClk,
   // Async reset, FIFO comes up empty
   input  logic                           PresetEmpty,

   //============================================================
   // Write port, WClk domain
   //============================================================
   input  logic [aFifoPkg::DataWidth-1:0] DataIn,
   input  logic                           WriteEn,
   // Writes are dropped while high
   output logic                           Full,

   //============================================================
   // Read port, RClk domain
   //============================================================
   input  logic                           ReadEn,
   // Valid on the accepting RClk edge
   output logic [aFifoPkg::DataWidth-1:0] DataOut,
   // Reads are ignored while high
   output logic                           Empty
);

   //============================================================
   // Internal signals
   //============================================================

   // Write accepted this WClk edge
   logic                              writeAccept;

   // Read accepted this RClk edge
   logic                              readAccept;

   // Next word to write, Gray coded
   logic [aFifoPkg::AddressWidth-1:0] writePtr;

   // Next word to read, Gray coded
   logic [aFifoPkg::AddressWidth-1:0] readPtr;

   //============================================================
   // Handshake gating
   //============================================================

   // Full blocks the write side
   always_comb begin
      writeAccept = WriteEn & ~Full;
   end

   // Empty blocks the read side
   always_comb begin
      readAccept = ReadEn & ~Empty;
   end

   //============================================================
   // Pointer counters
   //============================================================

   // Write pointer
   // Steps on every stored word
   grayCounter writeCounter (
      .Clk         (WClk),
      .PresetEmpty (PresetEmpty),
      .CountEn     (writeAccept),
      .GrayCount   (writePtr)
   );

   // Read pointer
   // Steps on every word delivered to DataOut
   grayCounter readCounter (
      .Clk         (RClk),
      .PresetEmpty (PresetEmpty),
      .CountEn     (readAccept),
      .GrayCount   (readPtr)
   );

   //============================================================
   // Storage
   //============================================================

   // Pointers address the array directly
   dualPortRam fifoRam (
      .WClk        (WClk),
      .WriteAddr   (writePtr),
      .WriteData   (DataIn),
      .WriteEn     (writeAccept),
      .RClk        (RClk),
      .PresetEmpty (PresetEmpty),
      .ReadAddr    (readPtr),
      .ReadEn      (readAccept),
      .ReadData    (DataOut)
   );

   //============================================================
   // Status
   //============================================================

   // Compares both Gray pointers across domains
   // Full returns to the write side, Empty to the read side
   statusFlags flags (
      .WClk        (WClk),
      .RClk        (RClk),
      .PresetEmpty (PresetEmpty),
      .WritePtr    (writePtr),
      .ReadPtr     (readPtr),
      .Full        (Full),
      .Empty       (Empty)
   );

endmodule

`default_nettype wire

/* verilog/aFifoPkg.sv */
//============================================================
// Shared FIFO sizes and the direction latch encoding
//============================================================

`default_nettype none

package aFifoPkg;

   //============================================================
   // Sizes
   //============================================================

   // Word width on both ports
   localparam int DataWidth = 8;

   // Pointer width, also the memory address width
   localparam int AddressWidth = 4;

   // Number of storage words
   // Always a power of two so Gray pointers wrap cleanly
   localparam int FifoDepth = 1 << AddressWidth;

   //============================================================
   // Direction latch
   //============================================================

   // Remembers which way the pointers last moved
   // Pointer equality alone cannot tell full from empty
   // GoingEmpty is the reset value
   typedef enum logic {
      GoingEmpty = 1'b0,
      GoingFull  = 1'b1
   } fifoDirT;

endpackage

`default_nettype wire

/* verilog/dualPortRam.sv */
//============================================================
// FIFO storage array, WClk write port and RClk read register
//============================================================

`timescale 1ns/1ps
`default_nettype none

module dualPortRam (
   //============================================================
   // Write side
   //============================================================
   input  logic                              WClk,
   // Gray write pointer used directly as the address
   input  logic [aFifoPkg::AddressWidth-1:0] WriteAddr,
   input  logic [aFifoPkg::DataWidth-1:0]    WriteData,
   // Already gated by not Full
   input  logic                              WriteEn,

   //============================================================
   // Read side
   //============================================================
   input  logic                              RClk,
   // Clears the read register
   input  logic                              PresetEmpty,
   // Gray read pointer used directly as the address
   input  logic [aFifoPkg::AddressWidth-1:0] ReadAddr,
   // Already gated by not Empty
   input  logic                              ReadEn,
   output logic [aFifoPkg::DataWidth-1:0]    ReadData
);

   // Storage words
   // Gray addresses still cover every location exactly once
   logic [aFifoPkg::DataWidth-1:0] mem [aFifoPkg::FifoDepth];

   //============================================================
   // Write port
   //============================================================

   // One word per accepted write
   always_ff @(posedge WClk) begin
      if (WriteEn) begin
         mem[WriteAddr] <= WriteData;
      end
   end

   //============================================================
   // Read port
   //============================================================

   // Oldest word lands in the register on the accepting edge
   // Holds its value while no read is accepted
   always_ff @(posedge RClk or posedge PresetEmpty) begin
      if (PresetEmpty) begin
         ReadData <= '0;
      end
      else if (ReadEn) begin
         ReadData <= mem[ReadAddr];
      end
   end

endmodule

`default_nettype wire

/* verilog/grayCounter.sv */
//============================================================
// Gray-code pointer counter with enable and async reset
//============================================================

`timescale 1ns/1ps
`default_nettype none

module grayCounter (
   // Counter clock, WClk or RClk depending on the instance
   input  logic                              Clk,
   // Async reset, restarts the pointer sequence at zero
   input  logic                              PresetEmpty,
   // Advance on this edge
   input  logic                              CountEn,
   // Registered Gray pointer
   output logic [aFifoPkg::AddressWidth-1:0] GrayCount
);

   //============================================================
   // Internal state
   //============================================================

   // Binary count, kept one step ahead of the Gray output
   logic [aFifoPkg::AddressWidth-1:0] binaryCount;

   // Gray code of the current binary count
   logic [aFifoPkg::AddressWidth-1:0] nextGray;

   //============================================================
   // Binary to Gray conversion
   //============================================================

   // Top bit passes through
   // Lower bits are xor of neighbouring binary bits
   always_comb begin
      nextGray = binaryCount ^ (binaryCount >> 1);
   end

   //============================================================
   // Count registers
   //============================================================

   // Binary starts at one so the first enabled edge
   // moves the pointer from 0 to gray(1)
   always_ff @(posedge Clk or posedge PresetEmpty) begin
      if (PresetEmpty) begin
         binaryCount <= {{(aFifoPkg::AddressWidth-1){1'b0}}, 1'b1};
         GrayCount   <= '0;
      end
      else if (CountEn) begin
         // Pointer takes the precomputed code
         GrayCount   <= nextGray;
         // Wraps naturally at FifoDepth
         binaryCount <= binaryCount + 1'b1;
      end
   end

   // Only one output bit flips per enabled edge
   // which makes the pointer safe to sample in the other domain

endmodule

`default_nettype wire

/* verilog/statusFlags.sv */
//============================================================
// Quadrant compare, direction latch, Full and Empty flops
//============================================================

`timescale 1ns/1ps
`default_nettype none

module statusFlags (
   // Write domain clock, clears Full
   input  logic                              WClk,
   // Read domain clock, clears Empty
   input  logic                              RClk,
   // Async reset toward empty
   input  logic                              PresetEmpty,
   // Gray pointers from both domains
   input  logic [aFifoPkg::AddressWidth-1:0] WritePtr,
   input  logic [aFifoPkg::AddressWidth-1:0] ReadPtr,
   // Status flags
   output logic                              Full,
   output logic                              Empty
);

   // Top two pointer bits select the quadrant
   localparam int MsbIdx = aFifoPkg::AddressWidth - 1;
   localparam int NsbIdx = aFifoPkg::AddressWidth - 2;

   //============================================================
   // Internal signals
   //============================================================

   // Pointers point at the same word
   logic              equalPtrs;

   // Write pointer one quadrant behind read pointer
   logic              goFull;

   // Write pointer one quadrant ahead of read pointer
   logic              goEmpty;

   // Direction latch state
   aFifoPkg::fifoDirT dirState;

   // Async set requests for the flags
   logic              fullPreset;
   logic              emptyPreset;

   //============================================================
   // Pointer compare
   //============================================================

   always_comb begin
      equalPtrs = (WritePtr == ReadPtr);
   end

   // Gray quadrants run 00, 01, 11, 10
   // Writer just behind reader means the FIFO is filling up
   always_comb begin
      goFull  = (WritePtr[NsbIdx] ~^ ReadPtr[MsbIdx]) &
                (WritePtr[MsbIdx] ^  ReadPtr[NsbIdx]);
   end

   // Writer just ahead of reader means it is draining
   always_comb begin
      goEmpty = (WritePtr[NsbIdx] ^  ReadPtr[MsbIdx]) &
                (WritePtr[MsbIdx] ~^ ReadPtr[NsbIdx]);
   end

   //============================================================
   // Direction latch
   //============================================================

   // Set/reset latch, reset side wins
   // Holds its value while pointers sit in other quadrants
   always_latch begin
      if (goEmpty || PresetEmpty) begin
         dirState <= aFifoPkg::GoingEmpty;
      end
      else if (goFull) begin
         dirState <= aFifoPkg::GoingFull;
      end
   end

   //============================================================
   // Flag presets
   //============================================================

   // Equal pointers mean full or empty, direction decides which
   always_comb begin
      fullPreset  = equalPtrs && (dirState == aFifoPkg::GoingFull);
      emptyPreset = equalPtrs && (dirState == aFifoPkg::GoingEmpty);
   end

   //============================================================
   // Full flop, write domain
   //============================================================

   // Rises at once on the preset
   // Falls on the first WClk edge after the match ends
   always_ff @(posedge WClk or posedge fullPreset or posedge PresetEmpty) begin
      if (PresetEmpty) begin
         Full <= 1'b0;
      end
      else if (fullPreset) begin
         Full <= 1'b1;
      end
      else begin
         Full <= 1'b0;
      end
   end

   //============================================================
   // Empty flop, read domain
   //============================================================

   // Reset also sets Empty
   // Falls on the first RClk edge after the match ends
   always_ff @(posedge RClk or posedge emptyPreset or posedge PresetEmpty) begin
      if (PresetEmpty) begin
         Empty <= 1'b1;
      end
      else if (emptyPreset) begin
         Empty <= 1'b1;
      end
      else begin
         Empty <= 1'b0;
      end
   end

endmodule

`default_nettype wire
